//--- compile.f
+incdir+hdl
hdl/cachePkg.sv
hdl/cacheTagArray.sv
hdl/cacheDataArray.sv
hdl/cacheLru.sv
hdl/cacheBusCtrl.sv
hdl/cacheTop.sv
testbench/cache_sva.sv
testbench/cacheTb.sv

//--- run.sh
#!/usr/bin/env bash
# Builds the cache testbench with Verilator, runs it and checks the log.

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/100ps \
	--top-module cacheTb -f compile.f -o cacheSim
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/cacheSim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
fi

if grep -q "^NO ERRORS$" "$LOG"; then
	echo "Simulation passed"
	exit 0
fi
echo "Simulation failed"
exit 1

//--- testbench/cacheTb.sv
`timescale 1ns/100ps
`include "cache_defs.svh"

module cacheTb;
	import cachePkg::*;

	localparam int clkPeriod = 100;
	localparam int maxWait = 3;
	localparam int numRandOps = 300;
	localparam int numDirOps = 60;
	localparam int cyclesPerOp = `LINE_WORDS * (maxWait + 1) + 4;

	logic   CLK;
	logic   RST_N;
	logic   cbusReq;
	logic   cbusWr;
	addrT   cbusA;
	dataT   cbusDi;
	byteEnT cbusBa;
	dataT   cbusDo;
	logic   cbusBusy;
	addrT   ibusA;
	dataT   ibusDi;
	dataT   ibusDo;
	byteEnT ibusBa;
	logic   ibusWe;
	logic   ibusReq;
	logic   ibusWait;
	logic   ibusLock;

	integer seed;
	int     errorCount;
	int     waitRun;
	logic   nextWait;
	tagT    tagPool [8];
	dataT   memory [addrT];

	// Beats seen on the external bus during the current CPU access.
	addrT   beatAddr [$];
	dataT   beatData [$];
	byteEnT beatBa [$];
	logic   beatWe [$];
	logic   beatLock [$];

	// The reference cache keeps the ways of each set oldest first in modelOrder.
	tagT  modelTag [`CACHE_SETS][`CACHE_WAYS];
	logic modelValid [`CACHE_SETS][`CACHE_WAYS];
	int   modelOrder [`CACHE_SETS][`CACHE_WAYS];

	cacheTop u_dut (
		.CLK(CLK), .RST_N(RST_N), .cbusReq(cbusReq), .cbusWr(cbusWr), .cbusA(cbusA),
		.cbusDi(cbusDi), .cbusBa(cbusBa), .cbusDo(cbusDo), .cbusBusy(cbusBusy),
		.ibusA(ibusA), .ibusDi(ibusDi), .ibusDo(ibusDo), .ibusBa(ibusBa), .ibusWe(ibusWe),
		.ibusReq(ibusReq), .ibusWait(ibusWait), .ibusLock(ibusLock)
	);

	function automatic logic [31:0] randWord();
		return $random(seed);
	endfunction

	function automatic addrT makeAddr(input logic [2:0] area, input tagT t, input setIdxT s,
		input wordIdxT w);
		return {area, t, s, w, 2'b00};
	endfunction

	// Unwritten memory words follow a pattern of their full address.
	function automatic dataT memRead(input addrT a);
		addrT k;
		k = {a[31:2], 2'b00};
		if (memory.exists(k)) begin
			return memory[k];
		end
		return {k[15:0], k[31:16]} ^ {k[7:0], k[31:8]} ^ 32'h3c5a96e1;
	endfunction

	task automatic memWrite(input addrT a, input dataT d, input byteEnT ba);
		dataT w;
		w = memRead(a);
		for (int b = 0; b < 4; b++) begin
			if (ba[b]) w[8*b +: 8] = d[8*b +: 8];
		end
		memory[{a[31:2], 2'b00}] = w;
	endtask

	task automatic checkEq(input logic [31:0] actual, input logic [31:0] expected,
		input string what);
		if (actual !== expected) begin
			errorCount++;
			$display("[ERROR] %0t ns: %s: got %h, expected %h", $time, what, actual, expected);
			$display("ERRORS FOUND");
			$fatal(1);
		end
	endtask

	task automatic modelReset();
		for (int s = 0; s < `CACHE_SETS; s++) begin
			for (int w = 0; w < `CACHE_WAYS; w++) begin
				modelTag[s][w] = '0;
				modelValid[s][w] = 1'b0;
				modelOrder[s][w] = `CACHE_WAYS - 1 - w;
			end
		end
	endtask

	function automatic int findWay(input addrT a);
		for (int w = 0; w < `CACHE_WAYS; w++) begin
			if (modelValid[a[9:4]][w] && modelTag[a[9:4]][w] == a[28:10]) return w;
		end
		return -1;
	endfunction

	task automatic modelTouch(input setIdxT s, input int way);
		int pos;
		pos = 0;
		for (int i = 0; i < `CACHE_WAYS; i++) begin
			if (modelOrder[s][i] == way) pos = i;
		end
		for (int i = pos; i < `CACHE_WAYS - 1; i++) begin
			modelOrder[s][i] = modelOrder[s][i + 1];
		end
		modelOrder[s][`CACHE_WAYS - 1] = way;
	endtask

	// Presents one request and waits for its completing edge.
	task automatic cpuAccess(input logic wr, input addrT a, input dataT d, input byteEnT ba,
		output dataT rd);
		beatAddr.delete();
		beatData.delete();
		beatBa.delete();
		beatWe.delete();
		beatLock.delete();
		cbusReq = 1'b1;
		cbusWr = wr;
		cbusA = a;
		cbusDi = d;
		cbusBa = ba;
		do begin
			@(negedge CLK);
		end while (cbusBusy);
		rd = cbusDo;
		@(posedge CLK);
		#10;
		cbusReq = 1'b0;
	endtask

	task automatic runOp(input logic wr, input addrT a, input dataT d, input byteEnT ba);
		dataT   rd;
		setIdxT s;
		int     way;
		int     victim;
		logic   cached;
		s = a[9:4];
		cached = (a[31:29] == `AREA_CACHED);
		way = cached ? findWay(a) : -1;
		cpuAccess(wr, a, d, ba, rd);
		if (wr && a[31:29] == `AREA_PURGE) begin
			checkEq(beatAddr.size(), 0, "beats on purge");
			for (int w = 0; w < `CACHE_WAYS; w++) begin
				if (modelTag[s][w] == a[28:10]) modelValid[s][w] = 1'b0;
			end
		end else if (wr || !cached) begin
			checkEq(beatAddr.size(), 1, "beats on write or uncached read");
			checkEq(beatAddr[0], a, "beat address");
			checkEq(32'(beatWe[0]), 32'(wr), "beat write enable");
			checkEq(32'(beatLock[0]), 0, "beat lock");
			if (wr) begin
				checkEq(beatData[0], d, "beat write data");
				checkEq(32'(beatBa[0]), 32'(ba), "beat byte enables");
			end
			if (way >= 0) modelTouch(s, way);
		end else if (way >= 0) begin
			checkEq(beatAddr.size(), 0, "beats on read hit");
			modelTouch(s, way);
		end else begin
			checkEq(beatAddr.size(), `LINE_WORDS, "beats on line fill");
			for (int k = 0; k < `LINE_WORDS; k++) begin
				checkEq(beatAddr[k], {a[31:4], wordIdxT'(a[3:2] + k + 1), 2'b00},
					"fill beat address");
				checkEq(32'(beatWe[k]), 0, "fill beat write enable");
				checkEq(32'(beatLock[k]), 1, "fill beat lock");
			end
			victim = modelOrder[s][0];
			modelTag[s][victim] = a[28:10];
			modelValid[s][victim] = 1'b1;
			modelTouch(s, victim);
		end
		if (!wr) checkEq(rd, memRead(a), "read data");
	endtask

	initial begin
		CLK = 1'b0;
		forever #(clkPeriod / 2) CLK = ~CLK;
	end

	// The external memory takes a beat at the negative edge before its completing edge.
	initial begin
		logic [31:0] r;
		forever begin
			@(negedge CLK);
			if (ibusReq && !ibusWait) begin
				beatAddr.push_back(ibusA);
				beatData.push_back(ibusWe ? ibusDo : ibusDi);
				beatBa.push_back(ibusBa);
				beatWe.push_back(ibusWe);
				beatLock.push_back(ibusLock);
				if (ibusWe) memWrite(ibusA, ibusDo, ibusBa);
			end
			r = randWord();
			nextWait = r[0] && (waitRun < maxWait);
			@(posedge CLK);
			#10;
			ibusWait = nextWait;
			waitRun = nextWait ? waitRun + 1 : 0;
			ibusDi = ibusReq ? memRead(ibusA) : '0;
		end
	end

	initial begin
		#(clkPeriod * (cyclesPerOp * (numRandOps + numDirOps) + 10));
		$display("Timeout: the cache did not finish all operations in the expected time.");
		$display("ERRORS FOUND");
		$fatal(1);
	end

	initial begin
		logic [31:0] r;
		logic [31:0] d;
		logic [2:0]  area;
		addrT        a;
		int          replSeq [11];
		seed = 32'h86adb713;
		errorCount = 0;
		waitRun = 0;
		nextWait = 1'b0;
		RST_N = 1'b0;
		cbusReq = 1'b0;
		cbusWr = 1'b0;
		cbusA = '0;
		cbusDi = '0;
		cbusBa = '0;
		ibusWait = 1'b0;
		ibusDi = '0;
		tagPool = '{19'h00005, 19'h00009, 19'h00100, 19'h00101, 19'h2a5c3, 19'h7ffff,
			19'h00000, 19'h13579};
		replSeq = '{0, 1, 2, 3, 4, 4, 1, 0, 2, 3, 1};
		modelReset();
		repeat (4) @(posedge CLK);
		#10;
		RST_N = 1'b1;
		@(posedge CLK);
		#10;

		runOp(1'b0, 32'h20000104, '0, 4'hF);
		runOp(1'b1, 32'h60000208, 32'hdeadbeef, 4'b0110);
		runOp(1'b0, 32'h60000208, '0, 4'hF);
		runOp(1'b0, makeAddr(`AREA_CACHED, 19'h00005, 6'd12, 2'd2), '0, 4'hF);
		runOp(1'b0, makeAddr(`AREA_CACHED, 19'h00005, 6'd12, 2'd2), '0, 4'hF);
		runOp(1'b0, makeAddr(`AREA_CACHED, 19'h00005, 6'd12, 2'd0), '0, 4'hF);
		runOp(1'b1, makeAddr(`AREA_CACHED, 19'h00005, 6'd12, 2'd1), 32'h12345678, 4'b0101);
		runOp(1'b0, makeAddr(`AREA_CACHED, 19'h00005, 6'd12, 2'd1), '0, 4'hF);
		runOp(1'b1, makeAddr(`AREA_CACHED, 19'h00009, 6'd12, 2'd3), 32'hcafef00d, 4'b1000);
		runOp(1'b0, makeAddr(`AREA_CACHED, 19'h00009, 6'd12, 2'd3), '0, 4'hF);
		runOp(1'b1, makeAddr(`AREA_PURGE, 19'h00005, 6'd12, 2'd0), '0, 4'hF);
		runOp(1'b0, makeAddr(`AREA_CACHED, 19'h00005, 6'd12, 2'd1), '0, 4'hF);
		// Five tags compete for set 30, then some of them are read again.
		foreach (replSeq[i]) begin
			runOp(1'b0, makeAddr(`AREA_CACHED, tagT'(19'h00100 + replSeq[i]), 6'd30, 2'd0),
				'0, 4'hF);
		end

		for (int i = 0; i < numRandOps; i++) begin
			r = randWord();
			d = randWord();
			area = r[8:6];
			if (area == `AREA_CACHED || area == `AREA_PURGE) area = 3'b111;
			if (r[11:9] <= 3'd3 || r[11:9] == 3'd7) area = `AREA_CACHED;
			if (r[11:9] == 3'd6) area = `AREA_PURGE;
			a = makeAddr(area, tagPool[r[2:0]], r[3] ? 6'd12 : 6'd30, r[5:4]);
			runOp(r[11:9] == 3'd3 || r[11:9] == 3'd5 || r[11:9] == 3'd6, a, d,
				(r[15:12] == 4'h0) ? 4'hF : r[15:12]);
		end

		if (errorCount == 0) begin
			$display("NO ERRORS");
		end else begin
			$display("ERRORS FOUND");
		end
		$finish;
	end

endmodule

//--- testbench/cache_sva.sv
`timescale 1ns/100ps

module cacheSva (
	input logic           CLK,
	input logic           RST_N,
	input logic           cbusReq,
	input logic           cbusBusy,
	input cachePkg::addrT ibusA,
	input cachePkg::dataT ibusDo,
	input logic           ibusWe,
	input logic           ibusReq,
	input logic           ibusWait,
	input logic           ibusLock
);

	// A beat that is held off by wait keeps its address and controls.
	assert property (@(posedge CLK) disable iff (!RST_N)
		(ibusReq && ibusWait) |=> ($stable(ibusA) && $stable(ibusWe) && $stable(ibusDo)))
		else $error("External bus changed while a beat was waiting");

	assert property (@(posedge CLK) disable iff (!RST_N) ibusLock |-> ibusReq)
		else $error("Bus lock high without an external request");

	// A waiting external beat holds the CPU request off.
	assert property (@(posedge CLK) disable iff (!RST_N)
		(cbusReq && ibusReq && ibusWait) |-> cbusBusy)
		else $error("CPU busy low while an external beat was waiting");

	assert property (@(posedge CLK) $rose(RST_N) |-> (!ibusReq && !ibusLock))
		else $error("External request or lock high in the first cycle after reset");

endmodule

bind cacheBusCtrl cacheSva u_sva (
	.CLK(CLK), .RST_N(RST_N), .cbusReq(cbusReq), .cbusBusy(cbusBusy), .ibusA(ibusA),
	.ibusDo(ibusDo), .ibusWe(ibusWe), .ibusReq(ibusReq), .ibusWait(ibusWait),
	.ibusLock(ibusLock)
);

//--- hdl/cacheTop.sv
`timescale 1ns/100ps

module cacheTop (
	input  logic             CLK,
	input  logic             RST_N,
	input  logic             cbusReq,
	input  logic             cbusWr,
	input  cachePkg::addrT   cbusA,
	input  cachePkg::dataT   cbusDi,
	input  cachePkg::byteEnT cbusBa,
	output cachePkg::dataT   cbusDo,
	output logic             cbusBusy,
	output cachePkg::addrT   ibusA,
	input  cachePkg::dataT   ibusDi,
	output cachePkg::dataT   ibusDo,
	output cachePkg::byteEnT ibusBa,
	output logic             ibusWe,
	output logic             ibusReq,
	input  logic             ibusWait,
	output logic             ibusLock
);
	import cachePkg::*;

	wayMaskT wayHit, victimWay, fillWay, wrWay, touchWay;
	addrT    fillAddr, wrAddr;
	dataT    cacheData, wrData;
	byteEnT  wrBa;
	logic    fillEn, purgeEn, wrEn, touchEn;

	cacheTagArray u_tags (
		.CLK(CLK), .RST_N(RST_N), .lookupAddr(cbusA), .fillEn(fillEn),
		.fillWay(fillWay), .fillAddr(fillAddr), .purgeEn(purgeEn), .wayHit(wayHit)
	);

	cacheDataArray u_data (
		.CLK(CLK), .RST_N(RST_N), .rdAddr(cbusA), .rdWay(wayHit), .wrEn(wrEn),
		.wrWay(wrWay), .wrAddr(wrAddr), .wrBa(wrBa), .wrData(wrData), .rdData(cacheData)
	);

	cacheLru u_lru (
		.CLK(CLK), .RST_N(RST_N), .setIdx(cbusA[9:4]), .touchEn(touchEn),
		.touchWay(touchWay), .victimWay(victimWay)
	);

	cacheBusCtrl u_ctrl (
		.CLK(CLK), .RST_N(RST_N), .cbusReq(cbusReq), .cbusWr(cbusWr), .cbusA(cbusA),
		.cbusDi(cbusDi), .cbusBa(cbusBa), .wayHit(wayHit), .victimWay(victimWay),
		.cacheData(cacheData), .ibusDi(ibusDi), .ibusWait(ibusWait), .cbusDo(cbusDo),
		.cbusBusy(cbusBusy), .ibusA(ibusA), .ibusDo(ibusDo), .ibusBa(ibusBa),
		.ibusWe(ibusWe), .ibusReq(ibusReq), .ibusLock(ibusLock), .fillEn(fillEn),
		.fillWay(fillWay), .fillAddr(fillAddr), .purgeEn(purgeEn), .wrEn(wrEn),
		.wrWay(wrWay), .wrAddr(wrAddr), .wrBa(wrBa), .wrData(wrData),
		.touchEn(touchEn), .touchWay(touchWay)
	);

endmodule

//--- hdl/cacheBusCtrl.sv
`timescale 1ns/100ps
`include "cache_defs.svh"

module cacheBusCtrl (
	input  logic              CLK,
	input  logic              RST_N,
	input  logic              cbusReq,
	input  logic              cbusWr,
	input  cachePkg::addrT    cbusA,
	input  cachePkg::dataT    cbusDi,
	input  cachePkg::byteEnT  cbusBa,
	input  cachePkg::wayMaskT wayHit,
	input  cachePkg::wayMaskT victimWay,
	input  cachePkg::dataT    cacheData,
	input  cachePkg::dataT    ibusDi,
	input  logic              ibusWait,
	output cachePkg::dataT    cbusDo,
	output logic              cbusBusy,
	output cachePkg::addrT    ibusA,
	output cachePkg::dataT    ibusDo,
	output cachePkg::byteEnT  ibusBa,
	output logic              ibusWe,
	output logic              ibusReq,
	output logic              ibusLock,
	output logic              fillEn,
	output cachePkg::wayMaskT fillWay,
	output cachePkg::addrT    fillAddr,
	output logic              purgeEn,
	output logic              wrEn,
	output cachePkg::wayMaskT wrWay,
	output cachePkg::addrT    wrAddr,
	output cachePkg::byteEnT  wrBa,
	output cachePkg::dataT    wrData,
	output logic              touchEn,
	output cachePkg::wayMaskT touchWay
);
	import cachePkg::*;

	ctrlStateT state;
	wayMaskT   fillWayReg;
	dataT      rdDataReg;
	wordIdxT   reqWord;
	wordIdxT   fillWord;
	logic      isCached, isPurge, hit, reqIdle, beatDone, lastBeat;
	logic      startWrite, startRead, startFill, writeHit, fillBeat, busyInt;

	assign isCached   = (cbusA[31:29] == `AREA_CACHED);
	assign isPurge    = (cbusA[31:29] == `AREA_PURGE);
	assign hit        = |wayHit;
	assign reqWord    = cbusA[3:2];
	assign fillWord   = ibusA[3:2];
	assign reqIdle    = (state == idle) && cbusReq;
	assign startWrite = reqIdle && cbusWr && !isPurge;
	assign startRead  = reqIdle && !cbusWr && !isCached;
	assign startFill  = reqIdle && !cbusWr && isCached && !hit;
	assign beatDone   = ibusReq && !ibusWait;
	// The fill wraps around the line so the requested word is the last beat.
	assign lastBeat   = (fillWord == reqWord);
	assign writeHit   = (state == busWrite) && beatDone && isCached && hit;
	assign fillBeat   = (state == lineFill) && beatDone;

	always_comb begin
		case (state)
			idle:     busyInt = cbusWr ? !isPurge : !(isCached && hit);
			readDone: busyInt = 1'b0;
			busWrite: busyInt = ibusWait;
			default:  busyInt = 1'b1;
		endcase
	end

	assign cbusBusy = cbusReq && busyInt;
	assign cbusDo   = (state == readDone) ? rdDataReg : cacheData;
	assign purgeEn  = reqIdle && cbusWr && isPurge;

	assign fillEn   = fillBeat;
	assign fillWay  = fillWayReg;
	assign fillAddr = ibusA;

	assign wrEn     = writeHit || fillBeat;
	assign wrWay    = (state == lineFill) ? fillWayReg : wayHit;
	assign wrAddr   = (state == lineFill) ? ibusA : cbusA;
	assign wrBa     = (state == lineFill) ? 4'hF : cbusBa;
	assign wrData   = (state == lineFill) ? ibusDi : cbusDi;

	assign touchEn  = (reqIdle && !cbusWr && isCached && hit) || writeHit || (fillBeat && lastBeat);
	assign touchWay = (state == lineFill) ? fillWayReg : wayHit;

	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			state    <= idle;
			ibusReq  <= 1'b0;
			ibusWe   <= 1'b0;
			ibusLock <= 1'b0;
		end else begin
			case (state)
				idle: begin
					if (startWrite) begin
						state   <= busWrite;
						ibusReq <= 1'b1;
						ibusWe  <= 1'b1;
					end else if (startRead) begin
						state   <= busRead;
						ibusReq <= 1'b1;
					end else if (startFill) begin
						state    <= lineFill;
						ibusReq  <= 1'b1;
						ibusLock <= 1'b1;
					end
				end
				busRead: begin
					if (beatDone) begin
						state   <= readDone;
						ibusReq <= 1'b0;
					end
				end
				readDone: state <= idle;
				busWrite: begin
					if (beatDone) begin
						state   <= idle;
						ibusReq <= 1'b0;
						ibusWe  <= 1'b0;
					end
				end
				lineFill: begin
					if (beatDone && lastBeat) begin
						state    <= idle;
						ibusReq  <= 1'b0;
						ibusLock <= 1'b0;
					end
				end
				default: state <= idle;
			endcase
		end
	end

	always_ff @(posedge CLK) begin
		if (startWrite || startRead) begin
			ibusA  <= cbusA;
			ibusBa <= cbusBa;
		end else if (startFill) begin
			ibusA      <= {cbusA[31:4], wordIdxT'(reqWord + 2'd1), 2'b00};
			ibusBa     <= 4'hF;
			fillWayReg <= victimWay;
		end else if (fillBeat) begin
			ibusA[3:2] <= wordIdxT'(fillWord + 2'd1);
		end
		if (startWrite) begin
			ibusDo <= cbusDi;
		end
		if ((state == busRead) && beatDone) begin
			rdDataReg <= ibusDi;
		end
	end

endmodule

//--- hdl/cacheLru.sv
`timescale 1ns/100ps
`include "cache_defs.svh"

module cacheLru (
	input  logic              CLK,
	input  logic              RST_N,
	input  cachePkg::setIdxT  setIdx,
	input  logic              touchEn,
	input  cachePkg::wayMaskT touchWay,
	output cachePkg::wayMaskT victimWay
);
	import cachePkg::*;

	lruBitsT lruBits [`CACHE_SETS];
	lruBitsT curBits;

	// Bit 5 orders ways 0/1, 4 ways 0/2, 3 ways 0/3, 2 ways 1/2, 1 ways 1/3, 0 ways 2/3.
	function automatic lruBitsT markUsed(input wayMaskT way, input lruBitsT bits);
		lruBitsT res;
		res = bits;
		case (1'b1)
			way[0]: res = {3'b000, bits[2:0]};
			way[1]: res = {1'b1, bits[4:3], 2'b00, bits[0]};
			way[2]: res = {bits[5], 1'b1, bits[3], 1'b1, bits[1], 1'b0};
			way[3]: res = {bits[5:4], 1'b1, bits[2], 2'b11};
			default: res = bits;
		endcase
		return res;
	endfunction

	assign curBits = lruBits[setIdx];

	always_comb begin
		casez (curBits)
			6'b111???: victimWay = 4'b0001;
			6'b0??11?: victimWay = 4'b0010;
			6'b?0?0?1: victimWay = 4'b0100;
			6'b??0?00: victimWay = 4'b1000;
			default:   victimWay = 4'b0001;
		endcase
	end

	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			for (int s = 0; s < `CACHE_SETS; s++) begin
				lruBits[s] <= '0;
			end
		end else if (touchEn) begin
			lruBits[setIdx] <= markUsed(touchWay, curBits);
		end
	end

endmodule

//--- hdl/cacheDataArray.sv
`timescale 1ns/100ps
`include "cache_defs.svh"

module cacheDataArray (
	input  logic              CLK,
	input  logic              RST_N,
	input  cachePkg::addrT    rdAddr,
	input  cachePkg::wayMaskT rdWay,
	input  logic              wrEn,
	input  cachePkg::wayMaskT wrWay,
	input  cachePkg::addrT    wrAddr,
	input  cachePkg::byteEnT  wrBa,
	input  cachePkg::dataT    wrData,
	output cachePkg::dataT    rdData
);
	import cachePkg::*;

	dataT mem [`CACHE_WAYS][`CACHE_SETS*`LINE_WORDS];

	// Word index within a way is the set and word fields together.
	logic [7:0] rdIdx;
	logic [7:0] wrIdx;

	assign rdIdx = rdAddr[9:2];
	assign wrIdx = wrAddr[9:2];

	always_comb begin
		rdData = '0;
		for (int w = 0; w < `CACHE_WAYS; w++) begin
			if (rdWay[w]) begin
				rdData = mem[w][rdIdx];
			end
		end
	end

	// Writes are held off while the cache is in reset.
	always_ff @(posedge CLK) begin
		if (wrEn && RST_N) begin
			for (int w = 0; w < `CACHE_WAYS; w++) begin
				for (int b = 0; b < $bits(byteEnT); b++) begin
					if (wrWay[w] && wrBa[b]) begin
						mem[w][wrIdx][8*b +: 8] <= wrData[8*b +: 8];
					end
				end
			end
		end
	end

endmodule

//--- hdl/cacheTagArray.sv
`timescale 1ns/100ps
`include "cache_defs.svh"

module cacheTagArray (
	input  logic              CLK,
	input  logic              RST_N,
	input  cachePkg::addrT    lookupAddr,
	input  logic              fillEn,
	input  cachePkg::wayMaskT fillWay,
	input  cachePkg::addrT    fillAddr,
	input  logic              purgeEn,
	output cachePkg::wayMaskT wayHit
);
	import cachePkg::*;

	tagT     tags [`CACHE_WAYS][`CACHE_SETS];
	wayMaskT validBits [`CACHE_SETS];

	setIdxT  lookupSet;
	tagT     lookupTag;
	setIdxT  fillSet;
	tagT     fillTag;
	wayMaskT tagMatch;

	assign lookupSet = lookupAddr[9:4];
	assign lookupTag = lookupAddr[28:10];
	assign fillSet   = fillAddr[9:4];
	assign fillTag   = fillAddr[28:10];

	always_comb begin
		for (int w = 0; w < `CACHE_WAYS; w++) begin
			tagMatch[w] = (tags[w][lookupSet] == lookupTag);
		end
		wayHit = tagMatch & validBits[lookupSet];
	end

	always_ff @(posedge CLK) begin
		if (fillEn) begin
			for (int w = 0; w < `CACHE_WAYS; w++) begin
				if (fillWay[w]) begin
					tags[w][fillSet] <= fillTag;
				end
			end
		end
	end

	// A purge drops every way whose tag matches, valid or not.
	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			for (int s = 0; s < `CACHE_SETS; s++) begin
				validBits[s] <= '0;
			end
		end else if (fillEn) begin
			validBits[fillSet] <= validBits[fillSet] | fillWay;
		end else if (purgeEn) begin
			validBits[lookupSet] <= validBits[lookupSet] & ~tagMatch;
		end
	end

endmodule

//--- hdl/cachePkg.sv
`include "cache_defs.svh"

package cachePkg;

	typedef logic [31:0] addrT;
	typedef logic [31:0] dataT;
	typedef logic [3:0]  byteEnT;
	typedef logic [`CACHE_WAYS-1:0] wayMaskT;

	// The tag is address bits 28..10, the set bits 9..4 and the word bits 3..2.
	typedef logic [$clog2(`CACHE_SETS)-1:0] setIdxT;
	typedef logic [18:0] tagT;
	typedef logic [$clog2(`LINE_WORDS)-1:0] wordIdxT;

	// One bit per pair of ways, as in the six-bit pairwise LRU scheme.
	typedef logic [5:0] lruBitsT;

	typedef enum logic [2:0] {
		idle,
		busRead,
		readDone,
		busWrite,
		lineFill
	} ctrlStateT;

endpackage

//--- hdl/cache_defs.svh
`ifndef CACHE_DEFS_SVH
`define CACHE_DEFS_SVH

// Cache geometry.
`define CACHE_WAYS 4
`define CACHE_SETS 64
`define LINE_WORDS 4

// Area codes held in address bits 31..29.
`define AREA_CACHED 3'b000
`define AREA_PURGE  3'b010

`endif
